/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui passes the u immediate
    } alu_op_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rd;
        alu_op_t  alu_op;
        logic     use_imm;      // operand b from imm
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;    // bne, else beq
        logic     reg_write;
    } de_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    alu_res;      // result or memory address
        word_t    store_data;
        reg_idx_t rd;
        logic     is_load;
        logic     is_store;
        logic     reg_write;
    } em_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    result;
        logic     reg_write;
    } mw_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     reg_write;
    } commit_t;

endpackage

/* fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
    parameter rv_pipe_pkg::word_t RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  redirect_i,
    input  rv_pipe_pkg::word_t    redirect_pc_i,
    output rv_pipe_pkg::mem_req_t ifetch_req_o,
    input  logic                  ifetch_resp_i,
    input  rv_pipe_pkg::word_t    ifetch_rdata_i,
    output rv_pipe_pkg::fd_t      fd_o
);

    rv_pipe_pkg::word_t pc_q;       // next fetch address
    rv_pipe_pkg::word_t addr_q;     // address of the request on the bus
    logic               busy_q;     // read strobe held
    logic               drop_q;     // in-flight fetch overtaken by a redirect
    rv_pipe_pkg::fd_t   hold_q;     // fetched word parked while decode stalls
    rv_pipe_pkg::fd_t   fd_q;
    rv_pipe_pkg::fd_t   fetched;
    logic               resp_ok;

    assign resp_ok = ifetch_resp_i && !drop_q && !redirect_i;
    assign fetched = '{valid: 1'b1, pc: addr_q, instr: ifetch_rdata_i};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q   <= RESET_PC;
            addr_q <= RESET_PC;
            busy_q <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            if (busy_q) begin
                if (ifetch_resp_i) begin
                    busy_q <= 1'b0;
                    drop_q <= 1'b0;
                end else if (redirect_i) begin
                    drop_q <= 1'b1;         // let it finish, discard the word
                end
            end else if (!hold_q.valid && !redirect_i) begin
                busy_q <= 1'b1;
                addr_q <= pc_q;
            end
            if (redirect_i)
                pc_q <= redirect_pc_i;
            else if (resp_ok)
                pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || redirect_i) begin
            fd_q.valid   <= 1'b0;
            hold_q.valid <= 1'b0;
        end else if (!stall_i) begin
            if (hold_q.valid) begin
                fd_q         <= hold_q;
                hold_q.valid <= 1'b0;
            end else if (resp_ok) begin
                fd_q <= fetched;
            end else begin
                fd_q.valid <= 1'b0;         // bubble
            end
        end else if (resp_ok) begin
            hold_q <= fetched;
        end
    end

    assign ifetch_req_o = '{read: busy_q, write: 1'b0, addr: addr_q, wdata: '0};
    assign fd_o         = fd_q;

endmodule

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic             clk,
    input  logic             rst_i,
    input  rv_pipe_pkg::fd_t fd_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  rv_pipe_pkg::em_t ex_rd_i,
    input  rv_pipe_pkg::mw_t mw_i,
    output logic             hazard_o,
    output rv_pipe_pkg::de_t de_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    rv_pipe_pkg::reg_idx_t rs1;
    rv_pipe_pkg::reg_idx_t rs2;
    rv_pipe_pkg::reg_idx_t rd;
    rv_pipe_pkg::word_t    imm_i;
    rv_pipe_pkg::word_t    imm_s;
    rv_pipe_pkg::word_t    imm_b;
    rv_pipe_pkg::word_t    imm_u;
    rv_pipe_pkg::word_t    regs [32];
    rv_pipe_pkg::de_t      de_d;
    rv_pipe_pkg::de_t      de_q;

    assign opcode = fd_i.instr[6:0];
    assign rd     = fd_i.instr[11:7];
    assign funct3 = fd_i.instr[14:12];
    assign rs1    = fd_i.instr[19:15];
    assign rs2    = fd_i.instr[24:20];

    assign imm_i = {{20{fd_i.instr[31]}}, fd_i.instr[31:20]};
    assign imm_s = {{20{fd_i.instr[31]}}, fd_i.instr[31:25], fd_i.instr[11:7]};
    assign imm_b = {{19{fd_i.instr[31]}}, fd_i.instr[31], fd_i.instr[7],
                    fd_i.instr[30:25], fd_i.instr[11:8], 1'b0};
    assign imm_u = {fd_i.instr[31:12], 12'b0};

    function automatic rv_pipe_pkg::alu_op_t func_op(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
            3'b010:  return rv_pipe_pkg::ALU_SLT;
            3'b100:  return rv_pipe_pkg::ALU_XOR;
            3'b110:  return rv_pipe_pkg::ALU_OR;
            3'b111:  return rv_pipe_pkg::ALU_AND;
            default: return rv_pipe_pkg::ALU_ADD;
        endcase
    endfunction

    // true when an older instruction still has to write r
    function automatic logic pending_write(input rv_pipe_pkg::reg_idx_t r);
        return (r != '0) &&
               ((de_q.valid && de_q.reg_write && de_q.rd == r) ||
                (ex_rd_i.valid && ex_rd_i.reg_write && ex_rd_i.rd == r) ||
                (mw_i.valid && mw_i.reg_write && mw_i.rd == r));
    endfunction

    always_comb begin
        hazard_o = fd_i.valid && (pending_write(rs1) || pending_write(rs2));
    end

    always_ff @(posedge clk) begin
        if (mw_i.valid && mw_i.reg_write)
            regs[mw_i.rd] <= mw_i.result;
    end

    always_comb begin
        de_d         = '0;
        de_d.pc      = fd_i.pc;
        de_d.rd      = rd;
        de_d.rs1_val = (rs1 == '0) ? '0 : regs[rs1];     // x0 reads zero
        de_d.rs2_val = (rs2 == '0) ? '0 : regs[rs2];
        case (opcode)
            rv_pipe_pkg::OPC_LUI: begin
                de_d.imm       = imm_u;
                de_d.use_imm   = 1'b1;
                de_d.alu_op    = rv_pipe_pkg::ALU_PASS_B;
                de_d.reg_write = 1'b1;
            end
            rv_pipe_pkg::OPC_OP_IMM: begin
                de_d.imm       = imm_i;
                de_d.use_imm   = 1'b1;
                de_d.alu_op    = func_op(funct3, 1'b0);
                de_d.reg_write = 1'b1;
            end
            rv_pipe_pkg::OPC_OP: begin
                de_d.alu_op    = func_op(funct3, fd_i.instr[30]);
                de_d.reg_write = 1'b1;
            end
            rv_pipe_pkg::OPC_LOAD: begin
                de_d.imm       = imm_i;
                de_d.use_imm   = 1'b1;
                de_d.is_load   = 1'b1;
                de_d.reg_write = 1'b1;
            end
            rv_pipe_pkg::OPC_STORE: begin
                de_d.imm      = imm_s;
                de_d.use_imm  = 1'b1;
                de_d.is_store = 1'b1;
            end
            rv_pipe_pkg::OPC_BRANCH: begin
                de_d.imm       = imm_b;
                de_d.is_branch = 1'b1;
                de_d.branch_ne = funct3[0];
            end
            default: ;                  // runs as a nop
        endcase
        if (rd == '0)
            de_d.reg_write = 1'b0;
        de_d.valid = fd_i.valid && !hazard_o && !flush_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            de_q.valid <= 1'b0;
        else if (!stall_i)
            de_q <= de_d;               // bubble on hazard or flush
    end

    assign de_o = de_q;

endmodule

/* exe_stage.sv */
`timescale 1ns/100ps

module exe_stage (
    input  logic               clk,
    input  logic               rst_i,
    input  rv_pipe_pkg::de_t   de_i,
    input  logic               stall_i,
    output logic               redirect_o,
    output rv_pipe_pkg::word_t redirect_pc_o,
    output rv_pipe_pkg::em_t   em_o
);

    rv_pipe_pkg::word_t op_b;
    rv_pipe_pkg::word_t alu_res;
    logic               taken;
    rv_pipe_pkg::em_t   em_q;

    assign op_b = de_i.use_imm ? de_i.imm : de_i.rs2_val;

    always_comb begin
        case (de_i.alu_op)
            rv_pipe_pkg::ALU_ADD:    alu_res = de_i.rs1_val + op_b;
            rv_pipe_pkg::ALU_SUB:    alu_res = de_i.rs1_val - op_b;
            rv_pipe_pkg::ALU_SLT:    alu_res = {31'b0, $signed(de_i.rs1_val) < $signed(op_b)};
            rv_pipe_pkg::ALU_XOR:    alu_res = de_i.rs1_val ^ op_b;
            rv_pipe_pkg::ALU_OR:     alu_res = de_i.rs1_val | op_b;
            rv_pipe_pkg::ALU_AND:    alu_res = de_i.rs1_val & op_b;
            rv_pipe_pkg::ALU_PASS_B: alu_res = op_b;
            default:                 alu_res = de_i.rs1_val + op_b;
        endcase
    end

    // beq and bne differ only in the sense of the compare
    assign taken = de_i.valid && de_i.is_branch &&
                   ((de_i.rs1_val == de_i.rs2_val) != de_i.branch_ne);

    // fires once, in the cycle the branch leaves execute
    assign redirect_o    = taken && !stall_i;
    assign redirect_pc_o = de_i.pc + de_i.imm;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            em_q.valid <= 1'b0;
        end else if (!stall_i) begin
            em_q.valid      <= de_i.valid;
            em_q.pc         <= de_i.pc;
            em_q.alu_res    <= alu_res;
            em_q.store_data <= de_i.rs2_val;
            em_q.rd         <= de_i.rd;
            em_q.is_load    <= de_i.is_load;
            em_q.is_store   <= de_i.is_store;
            em_q.reg_write  <= de_i.reg_write;
        end
    end

    assign em_o = em_q;

endmodule

/* mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_pipe_pkg::em_t      em_i,
    output rv_pipe_pkg::mem_req_t dmem_req_o,
    input  logic                  dmem_resp_i,
    input  rv_pipe_pkg::word_t    dmem_rdata_i,
    output logic                  stall_o,
    output rv_pipe_pkg::mw_t      mw_o
);

    logic             rd_req;
    logic             wr_req;
    rv_pipe_pkg::mw_t mw_q;

    assign rd_req = em_i.valid && em_i.is_load;
    assign wr_req = em_i.valid && em_i.is_store;

    // held steady by the frozen execute register until the response
    assign dmem_req_o = '{read: rd_req, write: wr_req, addr: em_i.alu_res,
                          wdata: em_i.store_data};
    assign stall_o    = (rd_req || wr_req) && !dmem_resp_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mw_q.valid <= 1'b0;
        end else begin
            mw_q.valid     <= em_i.valid && !stall_o;   // bubble while waiting
            mw_q.pc        <= em_i.pc;
            mw_q.rd        <= em_i.rd;
            mw_q.result    <= em_i.is_load ? dmem_rdata_i : em_i.alu_res;
            mw_q.reg_write <= em_i.reg_write;
        end
    end

    assign mw_o = mw_q;

endmodule

/* mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst_i,
    input  rv_pipe_pkg::mem_req_t ifetch_req_i,
    input  rv_pipe_pkg::mem_req_t dmem_req_i,
    output logic                  ifetch_resp_o,
    output logic                  dmem_resp_o,
    output rv_pipe_pkg::word_t    rdata_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output rv_pipe_pkg::word_t    mem_addr_o,
    output rv_pipe_pkg::word_t    mem_wdata_o,
    input  logic                  mem_resp_i,
    input  rv_pipe_pkg::word_t    mem_rdata_i
);

    typedef enum logic [1:0] {
        IDLE,
        GRANT_I,
        GRANT_D
    } arb_state_t;

    arb_state_t            state_q;
    rv_pipe_pkg::mem_req_t sel;
    logic                  active;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (dmem_req_i.read || dmem_req_i.write)
                        state_q <= GRANT_D;         // data side first
                    else if (ifetch_req_i.read || ifetch_req_i.write)
                        state_q <= GRANT_I;
                end
                GRANT_I, GRANT_D: begin
                    if (mem_resp_i)
                        state_q <= IDLE;            // grant locked until here
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign sel    = (state_q == GRANT_D) ? dmem_req_i : ifetch_req_i;
    assign active = (state_q != IDLE);

    assign mem_read_o  = active && sel.read;
    assign mem_write_o = active && sel.write;
    assign mem_addr_o  = sel.addr;
    assign mem_wdata_o = sel.wdata;

    assign ifetch_resp_o = (state_q == GRANT_I) && mem_resp_i;
    assign dmem_resp_o   = (state_q == GRANT_D) && mem_resp_i;
    assign rdata_o       = mem_rdata_i;

endmodule

/* rv_pipe_top.sv */
`timescale 1ns/100ps

module rv_pipe_top #(
    parameter rv_pipe_pkg::word_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst_i,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output rv_pipe_pkg::word_t   mem_addr_o,
    output rv_pipe_pkg::word_t   mem_wdata_o,
    input  logic                 mem_resp_i,
    input  rv_pipe_pkg::word_t   mem_rdata_i,
    output logic                 commit_valid_o,
    output rv_pipe_pkg::commit_t commit_o
);

    rv_pipe_pkg::fd_t      fd;
    rv_pipe_pkg::de_t      de;
    rv_pipe_pkg::em_t      em;
    rv_pipe_pkg::mw_t      mw;
    rv_pipe_pkg::mem_req_t ifetch_req;
    rv_pipe_pkg::mem_req_t dmem_req;
    rv_pipe_pkg::word_t    rdata;
    rv_pipe_pkg::word_t    redirect_pc;
    logic                  ifetch_resp;
    logic                  dmem_resp;
    logic                  stall_mem;
    logic                  hazard;
    logic                  stall_fetch;
    logic                  redirect;

    assign stall_fetch = stall_mem || hazard;   // fetch holds for either

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk            (clk),
        .rst_i          (rst_i),
        .stall_i        (stall_fetch),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .ifetch_req_o   (ifetch_req),
        .ifetch_resp_i  (ifetch_resp),
        .ifetch_rdata_i (rdata),
        .fd_o           (fd)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_i    (rst_i),
        .fd_i     (fd),
        .stall_i  (stall_mem),
        .flush_i  (redirect),
        .ex_rd_i  (em),
        .mw_i     (mw),
        .hazard_o (hazard),
        .de_o     (de)
    );

    exe_stage u_exe (
        .clk           (clk),
        .rst_i         (rst_i),
        .de_i          (de),
        .stall_i       (stall_mem),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .em_o          (em)
    );

    mem_stage u_mem (
        .clk          (clk),
        .rst_i        (rst_i),
        .em_i         (em),
        .dmem_req_o   (dmem_req),
        .dmem_resp_i  (dmem_resp),
        .dmem_rdata_i (rdata),
        .stall_o      (stall_mem),
        .mw_o         (mw)
    );

    mem_arbiter u_arb (
        .clk           (clk),
        .rst_i         (rst_i),
        .ifetch_req_i  (ifetch_req),
        .dmem_req_i    (dmem_req),
        .ifetch_resp_o (ifetch_resp),
        .dmem_resp_o   (dmem_resp),
        .rdata_o       (rdata),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_resp_i    (mem_resp_i),
        .mem_rdata_i   (mem_rdata_i)
    );

    // writeback retires one instruction per valid cycle
    assign commit_valid_o = mw.valid;
    assign commit_o       = '{pc: mw.pc, rd: mw.rd, wdata: mw.result, reg_write: mw.reg_write};

endmodule

/* rv_pipe_mem_model.sv */
`timescale 1ns/100ps

module rv_pipe_mem_model (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               mem_read_i,
    input  logic               mem_write_i,
    input  rv_pipe_pkg::word_t mem_addr_i,
    input  rv_pipe_pkg::word_t mem_wdata_i,
    output logic               mem_resp_o,
    output rv_pipe_pkg::word_t mem_rdata_o
);

    rv_pipe_pkg::word_t mem [256];      // loaded by the testbench
    int                 write_count;
    logic [31:0]        rng_q;
    int                 wait_cnt;
    logic               busy;
    logic               s_rst;
    logic               s_rd;
    logic               s_wr;
    rv_pipe_pkg::word_t s_addr;
    rv_pipe_pkg::word_t s_wdata;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        mem_resp_o  = 1'b0;
        mem_rdata_o = '0;
        write_count = 0;
        rng_q       = 32'he42b26ea;
        wait_cnt    = 0;
        busy        = 1'b0;
        forever begin
            @(posedge clk);
            s_rst   = rst_i;            // sample what the last cycle held
            s_rd    = mem_read_i;
            s_wr    = mem_write_i;
            s_addr  = mem_addr_i;
            s_wdata = mem_wdata_i;
            #1;
            if (s_rst || mem_resp_o) begin
                mem_resp_o = 1'b0;      // pulse lasts one cycle
                busy       = 1'b0;
            end else if (s_rd || s_wr) begin
                if (!busy) begin
                    busy     = 1'b1;
                    rng_q    = xorshift(rng_q);
                    wait_cnt = rng_q % 4;   // 0 to 3 idle cycles
                end
                if (wait_cnt == 0) begin
                    mem_resp_o = 1'b1;
                    if (s_wr) begin
                        mem[s_addr[9:2]] = s_wdata;
                        write_count++;
                    end else begin
                        mem_rdata_o = mem[s_addr[9:2]];
                    end
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

/* rv_pipe_tb.sv */
`timescale 1ns/100ps

module rv_pipe_tb;

    localparam rv_pipe_pkg::word_t RESET_PC = 32'h40;

    logic                 clk;
    logic                 rst_i;
    logic                 mem_read_o;
    logic                 mem_write_o;
    rv_pipe_pkg::word_t   mem_addr_o;
    rv_pipe_pkg::word_t   mem_wdata_o;
    logic                 mem_resp_i;
    rv_pipe_pkg::word_t   mem_rdata_i;
    logic                 commit_valid_o;
    rv_pipe_pkg::commit_t commit_o;

    rv_pipe_pkg::word_t prog [$];
    rv_pipe_pkg::word_t exp_mem [256];
    rv_pipe_pkg::word_t exp_pc [$];
    rv_pipe_pkg::word_t exp_wd [$];
    logic [4:0]         exp_rd [$];
    logic               exp_we [$];
    int                 exp_writes;
    int                 cidx;
    logic               checking;
    string              cur_test;
    int                 test_errs;
    int                 total_errs;
    int                 tests_run;
    int                 tests_failed;
    logic               pend;
    logic               prev_rd;
    logic               prev_wr;
    rv_pipe_pkg::word_t prev_addr;

    rv_pipe_top #(.RESET_PC(RESET_PC)) uut (.*);

    rv_pipe_mem_model mem_model (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem_read_i  (mem_read_o),
        .mem_write_i (mem_write_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_resp_o  (mem_resp_i),
        .mem_rdata_o (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic rv_pipe_pkg::word_t op_imm(input int f3, input int rd, input int rs1,
                                                  input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic rv_pipe_pkg::word_t op_reg(input int f7, input int f3, input int rd,
                                                  input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_pipe_pkg::word_t lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic rv_pipe_pkg::word_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic rv_pipe_pkg::word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_pipe_pkg::word_t branch(input int f3, input int rs1, input int rs2,
                                                  input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic rv_pipe_pkg::word_t fill_word(input int i);
        return (rv_pipe_pkg::word_t'(i) * 32'h9e3779b1) ^ 32'h5ac30f1e;
    endfunction

    // isa arithmetic on two operands as picked by f3
    function automatic rv_pipe_pkg::word_t alu_ref(input logic [2:0] f3, input logic sub,
                                                   input rv_pipe_pkg::word_t a,
                                                   input rv_pipe_pkg::word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic value_mismatch(input string what, input rv_pipe_pkg::word_t exp,
                                  input rv_pipe_pkg::word_t act);
        $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        test_errs++;
    endtask

    task automatic flag_problem(input string what);
        $display("ERROR %s: %s", cur_test, what);
        test_errs++;
    endtask

    // reference run of the program into the expected commit list
    task automatic interpret();
        rv_pipe_pkg::word_t regs [32];
        rv_pipe_pkg::word_t pc;
        rv_pipe_pkg::word_t ins;
        rv_pipe_pkg::word_t a;
        rv_pipe_pkg::word_t b;
        rv_pipe_pkg::word_t res;
        rv_pipe_pkg::word_t addr;
        rv_pipe_pkg::word_t next;
        rv_pipe_pkg::word_t imm_i;
        rv_pipe_pkg::word_t imm_s;
        rv_pipe_pkg::word_t imm_b;
        logic               we;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        exp_pc.delete();
        exp_wd.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_writes = 0;
        pc = RESET_PC;
        for (int step = 0; step < 500; step++) begin
            ins   = exp_mem[pc[9:2]];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            res   = '0;
            we    = 1'b0;
            next  = pc + 32'd4;
            case (ins[6:0])
                7'b0110111: begin
                    res = {ins[31:12], 12'b0};
                    we  = 1'b1;
                end
                7'b0010011: begin
                    res = alu_ref(ins[14:12], 1'b0, a, imm_i);
                    we  = 1'b1;
                end
                7'b0110011: begin
                    res = alu_ref(ins[14:12], ins[30], a, b);
                    we  = 1'b1;
                end
                7'b0000011: begin
                    addr = a + imm_i;
                    res  = exp_mem[addr[9:2]];
                    we   = 1'b1;
                end
                7'b0100011: begin
                    addr = a + imm_s;
                    exp_mem[addr[9:2]] = b;
                    exp_writes++;
                end
                7'b1100011: begin
                    if ((a == b) != ins[12])
                        next = pc + imm_b;
                end
                default: ;
            endcase
            if (ins[11:7] == 5'd0)
                we = 1'b0;
            if (we)
                regs[ins[11:7]] = res;
            exp_pc.push_back(pc);
            exp_rd.push_back(ins[11:7]);
            exp_wd.push_back(res);
            exp_we.push_back(we);
            if (ins == 32'h00000063)
                break;                  // self loop ends the program
            pc = next;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_i && checking && commit_valid_o) begin
            assert (commit_o.pc == exp_pc[cidx])
                else value_mismatch("commit pc", exp_pc[cidx], commit_o.pc);
            assert (commit_o.reg_write == exp_we[cidx])
                else value_mismatch("commit reg_write", rv_pipe_pkg::word_t'(exp_we[cidx]),
                                    rv_pipe_pkg::word_t'(commit_o.reg_write));
            if (exp_we[cidx]) begin
                assert (commit_o.rd == exp_rd[cidx])
                    else value_mismatch("commit rd", rv_pipe_pkg::word_t'(exp_rd[cidx]),
                                        rv_pipe_pkg::word_t'(commit_o.rd));
                assert (commit_o.wdata == exp_wd[cidx])
                    else value_mismatch("commit wdata", exp_wd[cidx], commit_o.wdata);
            end
            cidx++;
            if (cidx >= exp_pc.size())
                checking = 1'b0;
        end
    end

    // strobes hold steady until the response pulse
    always @(negedge clk) begin
        if (rst_i) begin
            pend = 1'b0;
        end else begin
            assert (!(mem_read_o && mem_write_o))
                else flag_problem("read and write strobes are high together");
            if (pend) begin
                assert (mem_read_o == prev_rd && mem_write_o == prev_wr)
                    else flag_problem("strobe dropped before the response");
                assert (mem_addr_o == prev_addr)
                    else value_mismatch("held bus address", prev_addr, mem_addr_o);
            end
            pend      = (mem_read_o || mem_write_o) && !mem_resp_i;
            prev_rd   = mem_read_o;
            prev_wr   = mem_write_o;
            prev_addr = mem_addr_o;
        end
    end

    task automatic run_test(input string name);
        int n;
        int base;
        cur_test  = name;
        test_errs = 0;
        base      = RESET_PC[9:2];      // program starts at the reset address
        for (int i = 0; i < 256; i++)
            exp_mem[i] = (i >= base && i < base + prog.size()) ? prog[i - base]
                                                                : fill_word(i);
        @(posedge clk);
        #1 rst_i = 1'b1;
        @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < 256; i++)
            mem_model.mem[i] = exp_mem[i];
        mem_model.write_count = 0;
        interpret();
        cidx     = 0;
        checking = 1'b1;
        assert (!mem_read_o && !mem_write_o && !commit_valid_o)
            else flag_problem("strobe or commit high during reset");
        @(posedge clk);
        #1 rst_i = 1'b0;
        for (n = 0; n < 50 && !mem_read_o; n++)
            @(negedge clk);
        if (!mem_read_o)
            flag_problem("timed out waiting for the first fetch");
        else
            assert (mem_addr_o == RESET_PC)
                else value_mismatch("first fetch address", RESET_PC, mem_addr_o);
        for (n = 0; n < 5000 && checking; n++)
            @(negedge clk);
        if (checking) begin
            flag_problem("timed out waiting for the last commit");
            checking = 1'b0;
        end
        for (int i = 0; i < 256; i++)
            assert (mem_model.mem[i] == exp_mem[i])
                else value_mismatch($sformatf("memory word %0d", i), exp_mem[i],
                                    mem_model.mem[i]);
        assert (mem_model.write_count == exp_writes)
            else value_mismatch("store count", exp_writes, mem_model.write_count);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, test_errs);
        end else begin
            $display("PASS %s, %0d commits", name, exp_pc.size());
        end
        total_errs += test_errs;
    endtask

    initial begin
        rst_i        = 1'b1;
        checking     = 1'b0;
        cidx         = 0;
        pend         = 1'b0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;

        prog = '{lui(1, 'h80000), op_imm(0, 2, 0, -5), op_imm(2, 3, 2, 1),
                 op_imm(4, 4, 2, 'h0ff), op_imm(6, 5, 0, 'h123), op_imm(7, 6, 2, 'h0f0),
                 op_reg(0, 0, 7, 2, 5), op_reg('h20, 0, 8, 2, 5), op_reg(0, 2, 9, 2, 0),
                 op_reg(0, 2, 10, 5, 2), op_reg(0, 4, 11, 1, 5), op_reg(0, 6, 12, 1, 2),
                 op_reg(0, 7, 13, 2, 5), op_imm(0, 0, 0, 7), op_reg(0, 0, 14, 0, 0),
                 op_reg(0, 2, 15, 1, 2), branch(0, 0, 0, 0)};
        run_test("alu");

        prog = '{op_imm(0, 1, 0, 1), op_reg(0, 0, 1, 1, 1), op_reg(0, 0, 1, 1, 1),
                 op_reg(0, 0, 2, 1, 1), op_reg('h20, 0, 3, 2, 1), op_imm(4, 3, 3, -1),
                 op_reg(0, 2, 4, 3, 2), op_reg(0, 0, 5, 4, 3), branch(0, 0, 0, 0)};
        run_test("interlock");

        prog = '{op_imm(0, 1, 0, 'h200), op_imm(0, 2, 0, -77), sw(2, 1, 0), lw(3, 1, 0),
                 op_reg(0, 0, 4, 3, 3), sw(4, 1, 4), lw(5, 1, 4), lw(6, 1, 8),
                 op_reg(0, 4, 7, 6, 5), sw(7, 1, 12), branch(0, 0, 0, 0)};
        run_test("load_store");

        prog = '{op_imm(0, 1, 0, 3), op_imm(0, 2, 0, 3), branch(0, 1, 2, 8),
                 op_imm(0, 3, 0, 99), branch(1, 1, 2, 8), op_imm(0, 4, 0, 1),
                 op_imm(0, 10, 0, 'h200), branch(1, 1, 0, 12), sw(1, 10, 0),
                 op_imm(0, 5, 0, 55), branch(0, 4, 0, 8), op_imm(0, 6, 0, 7),
                 branch(0, 0, 0, 0)};
        run_test("branch");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (total_errs == 0 && tests_failed == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* rv_pipe.f */
rv_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
exe_stage.sv
mem_stage.sv
mem_arbiter.sv
rv_pipe_top.sv
rv_pipe_mem_model.sv
rv_pipe_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f rv_pipe.f --top-module rv_pipe_tb -Mdir obj_dir

run: compile
	./obj_dir/Vrv_pipe_tb | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
